//--- hw/bus_defs.svh
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// machine timer, low and high word of mtime
`define CLINT_MTIME_ADDR    32'h0200_bff8
`define CLINT_MTIME_HI_ADDR 32'h0200_bffc

// console byte port, store only
`define CONSOLE_ADDR        32'h1000_0000

// sram depth in words
// index comes from address bits 11:2
`define MEM_WORDS           1024

// 1 lets the lfsr stall sram ready, 0 gives fixed one-cycle latency
`define MEM_JITTER_EN       1

// cycles between two console output bytes
`define CONSOLE_DRAIN       8

`endif

//--- hw/bus_pkg.sv
package bus_pkg;

  // byte address on the shared data path
  typedef logic [31:0] addr_t;

  // one bus word
  typedef logic [31:0] data_t;

  // byte lane enables, bit n covers data bits 8n+7:8n
  typedef logic [3:0] strb_t;

  // single console character
  typedef logic [7:0] byte_t;

endpackage

//--- hw/dev_pkg.sv
package dev_pkg;

  // target picked by the address decoder
  typedef enum logic [1:0] {
    DEV_SRAM,
    DEV_CLINT,
    DEV_CONSOLE
  } dev_sel_e;

  // owner of the sram read in flight
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_IFU,
    ARB_LSU
  } arb_state_e;

  // free-running cycle count
  typedef logic [63:0] mtime_t;

endpackage

//--- hw/mem_if.sv
`timescale 1ns/10ps

interface mem_if import bus_pkg::*; ();

  // read channel
  addr_t araddr;
  logic  arvalid;
  data_t rdata;
  logic  rvalid;

  // write channel, address and data travel together
  addr_t awaddr;
  data_t wdata;
  strb_t wstrb;
  logic  wvalid;
  logic  wready;

  modport arbiter (
    output araddr,
    output arvalid,
    input  rdata,
    input  rvalid,
    output awaddr,
    output wdata,
    output wstrb,
    output wvalid,
    input  wready
  );

  modport memory (
    input  araddr,
    input  arvalid,
    output rdata,
    output rvalid,
    input  awaddr,
    input  wdata,
    input  wstrb,
    input  wvalid,
    output wready
  );

endinterface

//--- hw/bus_arbiter.sv
`timescale 1ns/10ps
`include "bus_defs.svh"

module bus_arbiter import bus_pkg::*, dev_pkg::*; (
  input  logic  clk,
  input  logic  rst,

  // instruction fetch, read only
  input  addr_t ifu_araddr_i,
  input  logic  ifu_arvalid_i,
  output data_t ifu_rdata_o,
  output logic  ifu_rvalid_o,

  // load/store, read side
  input  addr_t lsu_araddr_i,
  input  logic  lsu_arvalid_i,
  output data_t lsu_rdata_o,
  output logic  lsu_rvalid_o,

  // load/store, write side
  input  addr_t lsu_awaddr_i,
  input  data_t lsu_wdata_i,
  input  strb_t lsu_wstrb_i,
  input  logic  lsu_wvalid_i,
  output logic  lsu_wready_o,

  mem_if.arbiter mem,

  // timer link
  output logic  clint_req_o,
  output addr_t clint_addr_o,
  input  data_t clint_rdata_i,
  input  logic  clint_rvalid_i,

  // console link
  output byte_t con_wdata_o,
  output logic  con_wvalid_o,
  input  logic  con_wready_i
);

  dev_sel_e   load_sel;
  dev_sel_e   store_sel;
  arb_state_e state;
  logic       lsu_rd_sram;

  // only the two mtime words live outside the sram for loads
  assign load_sel = (lsu_araddr_i == `CLINT_MTIME_ADDR ||
                     lsu_araddr_i == `CLINT_MTIME_HI_ADDR) ? DEV_CLINT : DEV_SRAM;

  // timer addresses are not writable, those stores land in the sram
  assign store_sel = (lsu_awaddr_i == `CONSOLE_ADDR) ? DEV_CONSOLE : DEV_SRAM;

  assign lsu_rd_sram = lsu_arvalid_i && (load_sel == DEV_SRAM);

  // read owner, held from first presentation to rvalid
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ARB_IDLE;
    end else begin
      case (state)
        ARB_IDLE: begin
          // load/store wins a tie
          if (lsu_rd_sram) begin
            state <= ARB_LSU;
          end else if (ifu_arvalid_i) begin
            state <= ARB_IFU;
          end
        end
        ARB_IFU, ARB_LSU: begin
          if (mem.rvalid) begin
            state <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // sram read mux, fields stay fixed while an owner is recorded
  always_comb begin
    case (state)
      ARB_IFU: begin
        mem.arvalid = ifu_arvalid_i;
        mem.araddr  = ifu_araddr_i;
      end
      ARB_LSU: begin
        mem.arvalid = lsu_rd_sram;
        mem.araddr  = lsu_araddr_i;
      end
      default: begin
        mem.arvalid = lsu_rd_sram || ifu_arvalid_i;
        mem.araddr  = lsu_rd_sram ? lsu_araddr_i : ifu_araddr_i;
      end
    endcase
  end

  // sram write side
  assign mem.awaddr = lsu_awaddr_i;
  assign mem.wdata  = lsu_wdata_i;
  assign mem.wstrb  = lsu_wstrb_i;
  assign mem.wvalid = lsu_wvalid_i && (store_sel == DEV_SRAM);

  // timer and console requests
  assign clint_req_o  = lsu_arvalid_i && (load_sel == DEV_CLINT);
  assign clint_addr_o = lsu_araddr_i;
  assign con_wdata_o  = lsu_wdata_i[7:0];
  assign con_wvalid_o = lsu_wvalid_i && (store_sel == DEV_CONSOLE);

  // responses back to their owners
  assign ifu_rdata_o  = mem.rdata;
  assign ifu_rvalid_o = mem.rvalid && (state == ARB_IFU);

  // one load outstanding, so timer and sram never answer together
  assign lsu_rdata_o  = clint_rvalid_i ? clint_rdata_i : mem.rdata;
  assign lsu_rvalid_o = (mem.rvalid && (state == ARB_LSU)) || clint_rvalid_i;
  assign lsu_wready_o = mem.wready || con_wready_i;

endmodule

//--- hw/mem_sram.sv
`timescale 1ns/10ps
`include "bus_defs.svh"

module mem_sram import bus_pkg::*; (
  input  logic clk,
  input  logic rst,
  mem_if.memory mem
);

  localparam int IDX_W     = $clog2(`MEM_WORDS);
  localparam bit JITTER_EN = `MEM_JITTER_EN;

  data_t             ram [`MEM_WORDS];
  logic [19:0]       lfsr;
  logic              lfsr_ok;
  logic              busy;
  logic              take_rd;
  logic              take_wr;
  logic [IDX_W-1:0]  rd_idx;
  logic [IDX_W-1:0]  wr_idx;

  initial begin
    for (int i = 0; i < `MEM_WORDS; i++) begin
      ram[i] = '0;
    end
  end

  assign lfsr_ok = JITTER_EN ? lfsr[19] : 1'b1;
  assign rd_idx  = mem.araddr[IDX_W+1:2];
  assign wr_idx  = mem.awaddr[IDX_W+1:2];

  // read wins when both are pending
  assign take_rd = lfsr_ok && !busy && mem.arvalid;
  assign take_wr = lfsr_ok && !busy && !mem.arvalid && mem.wvalid;

  // busy covers the response cycle so a held request is not taken twice
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr       <= 20'd1;
      busy       <= 1'b0;
      mem.rvalid <= 1'b0;
      mem.wready <= 1'b0;
    end else begin
      // taps 20 and 17
      lfsr       <= {lfsr[18:0], lfsr[19] ^ lfsr[16]};
      busy       <= take_rd || take_wr;
      mem.rvalid <= take_rd;
      mem.wready <= take_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (take_rd) begin
      mem.rdata <= ram[rd_idx];
    end
    if (take_wr) begin
      for (int b = 0; b < 4; b++) begin
        if (mem.wstrb[b]) begin
          ram[wr_idx][8*b +: 8] <= mem.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- hw/clint_timer.sv
`timescale 1ns/10ps

module clint_timer import bus_pkg::*, dev_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  req_i,
  input  addr_t addr_i,
  output data_t rdata_o,
  output logic  rvalid_o
);

  mtime_t mtime;
  logic   take;

  // request is a level, skip the cycle that already answers it
  assign take = req_i && !rvalid_o;

  // zero in the first cycle after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= take;
    end
  end

  // bit 2 picks the high word at 0x...bffc
  always_ff @(posedge clk) begin
    if (take) begin
      rdata_o <= addr_i[2] ? mtime[63:32] : mtime[31:0];
    end
  end

endmodule

//--- hw/console_port.sv
`timescale 1ns/10ps
`include "bus_defs.svh"

module console_port import bus_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  byte_t wdata_i,
  input  logic  wvalid_i,
  output logic  wready_o,
  output byte_t console_data_o,
  output logic  console_valid_o
);

  localparam int DEPTH   = 4;
  localparam int CNT_W   = $clog2(DEPTH + 1);
  localparam int DRAIN_W = $clog2(`CONSOLE_DRAIN + 1);

  byte_t              fifo [DEPTH];
  logic [1:0]         wr_ptr;
  logic [1:0]         rd_ptr;
  logic [CNT_W-1:0]   count;
  logic [DRAIN_W-1:0] drain_cnt;
  logic               push;
  logic               pop;

  // no push while wready is out, the writer still holds the old byte
  assign push = wvalid_i && (count != CNT_W'(DEPTH)) && !wready_o;
  assign pop  = (count != '0) && (drain_cnt == DRAIN_W'(`CONSOLE_DRAIN - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      count           <= '0;
      drain_cnt       <= '0;
      wready_o        <= 1'b0;
      console_valid_o <= 1'b0;
    end else begin
      wready_o        <= push;
      console_valid_o <= pop;
      if (push) begin
        wr_ptr <= wr_ptr + 2'd1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 2'd1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
      // rate timer runs only while bytes wait
      if (count == '0 || pop) begin
        drain_cnt <= '0;
      end else begin
        drain_cnt <= drain_cnt + DRAIN_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo[wr_ptr] <= wdata_i;
    end
    if (pop) begin
      console_data_o <= fifo[rd_ptr];
    end
  end

endmodule

//--- hw/soc_bus_top.sv
`timescale 1ns/10ps

module soc_bus_top import bus_pkg::*; (
  input  logic  clk,
  input  logic  rst,

  input  addr_t ifu_araddr_i,
  input  logic  ifu_arvalid_i,
  output data_t ifu_rdata_o,
  output logic  ifu_rvalid_o,

  input  addr_t lsu_araddr_i,
  input  logic  lsu_arvalid_i,
  output data_t lsu_rdata_o,
  output logic  lsu_rvalid_o,

  input  addr_t lsu_awaddr_i,
  input  data_t lsu_wdata_i,
  input  strb_t lsu_wstrb_i,
  input  logic  lsu_wvalid_i,
  output logic  lsu_wready_o,

  output byte_t console_data_o,
  output logic  console_valid_o
);

  // timer link
  logic  clint_req;
  addr_t clint_addr;
  data_t clint_rdata;
  logic  clint_rvalid;

  // console link
  byte_t con_wdata;
  logic  con_wvalid;
  logic  con_wready;

  mem_if i_mem_if ();

  bus_arbiter i_bus_arbiter (
    .clk            (clk),
    .rst            (rst),
    .ifu_araddr_i   (ifu_araddr_i),
    .ifu_arvalid_i  (ifu_arvalid_i),
    .ifu_rdata_o    (ifu_rdata_o),
    .ifu_rvalid_o   (ifu_rvalid_o),
    .lsu_araddr_i   (lsu_araddr_i),
    .lsu_arvalid_i  (lsu_arvalid_i),
    .lsu_rdata_o    (lsu_rdata_o),
    .lsu_rvalid_o   (lsu_rvalid_o),
    .lsu_awaddr_i   (lsu_awaddr_i),
    .lsu_wdata_i    (lsu_wdata_i),
    .lsu_wstrb_i    (lsu_wstrb_i),
    .lsu_wvalid_i   (lsu_wvalid_i),
    .lsu_wready_o   (lsu_wready_o),
    .mem            (i_mem_if.arbiter),
    .clint_req_o    (clint_req),
    .clint_addr_o   (clint_addr),
    .clint_rdata_i  (clint_rdata),
    .clint_rvalid_i (clint_rvalid),
    .con_wdata_o    (con_wdata),
    .con_wvalid_o   (con_wvalid),
    .con_wready_i   (con_wready)
  );

  mem_sram i_mem_sram (
    .clk (clk),
    .rst (rst),
    .mem (i_mem_if.memory)
  );

  clint_timer i_clint_timer (
    .clk      (clk),
    .rst      (rst),
    .req_i    (clint_req),
    .addr_i   (clint_addr),
    .rdata_o  (clint_rdata),
    .rvalid_o (clint_rvalid)
  );

  console_port i_console_port (
    .clk             (clk),
    .rst             (rst),
    .wdata_i         (con_wdata),
    .wvalid_i        (con_wvalid),
    .wready_o        (con_wready),
    .console_data_o  (console_data_o),
    .console_valid_o (console_valid_o)
  );

endmodule

//--- dv/tb_soc_bus.sv
`timescale 1ns/10ps
`include "bus_defs.svh"

module tb_soc_bus import bus_pkg::*, dev_pkg::*; ();

  localparam int N_PH1     = 200;
  localparam int N_FETCH   = 150;
  localparam int N_LSU     = 150;
  localparam int N_TIMER   = 40;
  localparam int N_BURSTS  = 3;
  localparam int BURST_LEN = 10;
  // store and load per phase one step, plus four timer store/load ops at the end
  localparam int N_OPS = 2 * N_PH1 + N_FETCH + N_LSU + N_TIMER + N_BURSTS * BURST_LEN + 4;
  localparam int TIMEOUT_CYCLES = N_OPS * 40 + 2000;

  logic  clk;
  logic  rst;
  addr_t ifu_araddr;
  logic  ifu_arvalid;
  data_t ifu_rdata;
  logic  ifu_rvalid;
  addr_t lsu_araddr;
  logic  lsu_arvalid;
  data_t lsu_rdata;
  logic  lsu_rvalid;
  addr_t lsu_awaddr;
  data_t lsu_wdata;
  strb_t lsu_wstrb;
  logic  lsu_wvalid;
  logic  lsu_wready;
  byte_t console_data;
  logic  console_valid;

  // reference model state
  integer      seed;
  data_t       mem_model [`MEM_WORDS];
  mtime_t      mtime_model;
  byte_t       con_q [$];
  int          written [$];
  int unsigned cycle_count;

  soc_bus_top i_soc_bus_top (
    .clk             (clk),
    .rst             (rst),
    .ifu_araddr_i    (ifu_araddr),
    .ifu_arvalid_i   (ifu_arvalid),
    .ifu_rdata_o     (ifu_rdata),
    .ifu_rvalid_o    (ifu_rvalid),
    .lsu_araddr_i    (lsu_araddr),
    .lsu_arvalid_i   (lsu_arvalid),
    .lsu_rdata_o     (lsu_rdata),
    .lsu_rvalid_o    (lsu_rvalid),
    .lsu_awaddr_i    (lsu_awaddr),
    .lsu_wdata_i     (lsu_wdata),
    .lsu_wstrb_i     (lsu_wstrb),
    .lsu_wvalid_i    (lsu_wvalid),
    .lsu_wready_o    (lsu_wready),
    .console_data_o  (console_data),
    .console_valid_o (console_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t ns: %s, got %08h expected %08h",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t ns: %s, got %02h expected %02h",
                          $time, what, got, exp));
    end
  endtask

  function automatic data_t merge_strb(input data_t old_w, input data_t new_w,
                                       input strb_t strb);
    data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic addr_t word_addr(input int idx);
    return addr_t'(idx) << 2;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'({$random(seed)} % (hi - lo + 1));
  endfunction

  // counts mtime, zero until the first edge after reset release
  always @(posedge clk) begin
    if (!rst) begin
      mtime_model <= mtime_model + 64'd1;
    end
  end

  // every console byte must match the oldest accepted one
  always @(negedge clk) begin
    if (console_valid === 1'b1) begin
      if (con_q.size() == 0) begin
        abort_run($sformatf("console sent byte %02h at %0t ns but no byte was waiting",
                            console_data, $time));
      end else begin
        check_byte(console_data, con_q.pop_front(), "console output");
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    abort_run($sformatf("timeout after %0d cycles, a bus handshake never completed",
                        TIMEOUT_CYCLES));
  end

  task automatic ifu_idle(input int n);
    repeat (n) begin
      @(negedge clk);
      if (ifu_rvalid) begin
        abort_run("fetch port returned data with no fetch pending");
      end
    end
  endtask

  task automatic lsu_idle(input int n);
    repeat (n) begin
      @(negedge clk);
      if (lsu_rvalid || lsu_wready) begin
        abort_run("load/store port answered with no request pending");
      end
    end
  endtask

  task automatic fetch(input addr_t addr);
    data_t exp;
    ifu_araddr  = addr;
    ifu_arvalid = 1'b1;
    exp = mem_model[addr[11:2]];
    do begin
      @(negedge clk);
    end while (!ifu_rvalid);
    ifu_arvalid = 1'b0;
    check_data(ifu_rdata, exp, $sformatf("fetch from %08h", addr));
  endtask

  task automatic lsu_store(input addr_t addr, input data_t data, input strb_t strb);
    lsu_awaddr = addr;
    lsu_wdata  = data;
    lsu_wstrb  = strb;
    lsu_wvalid = 1'b1;
    do begin
      @(negedge clk);
      if (lsu_rvalid) begin
        abort_run("load data came back while only a store was pending");
      end
    end while (!lsu_wready);
    lsu_wvalid = 1'b0;
    if (addr == `CONSOLE_ADDR) begin
      con_q.push_back(data[7:0]);
    end else begin
      // timer addresses alias into the sram like any other store
      mem_model[addr[11:2]] = merge_strb(mem_model[addr[11:2]], data, strb);
    end
  endtask

  task automatic lsu_load(input addr_t addr, input string what);
    data_t exp;
    logic  is_timer;
    is_timer = (addr == `CLINT_MTIME_ADDR) || (addr == `CLINT_MTIME_HI_ADDR);
    // timer needs a quiet cycle after its last answer
    if (is_timer) begin
      lsu_idle(1);
    end
    lsu_araddr  = addr;
    lsu_arvalid = 1'b1;
    if (addr == `CLINT_MTIME_ADDR) begin
      exp = mtime_model[31:0];
    end else if (addr == `CLINT_MTIME_HI_ADDR) begin
      exp = mtime_model[63:32];
    end else begin
      exp = mem_model[addr[11:2]];
    end
    do begin
      @(negedge clk);
      if (lsu_wready) begin
        abort_run("store acknowledge came back while only a load was pending");
      end
    end while (!lsu_rvalid);
    lsu_arvalid = 1'b0;
    check_data(lsu_rdata, exp, $sformatf("%s at %08h", what, addr));
  endtask

  task automatic store_random_word(input int idx);
    data_t wd;
    strb_t st;
    wd = $random(seed);
    st = strb_t'($random(seed));
    lsu_store(word_addr(idx), wd, st);
  endtask

  initial begin : stimulus
    int idx;
    seed        = 32'h423a_49bf;
    rst         = 1'b1;
    ifu_araddr  = '0;
    ifu_arvalid = 1'b0;
    lsu_araddr  = '0;
    lsu_arvalid = 1'b0;
    lsu_awaddr  = '0;
    lsu_wdata   = '0;
    lsu_wstrb   = '0;
    lsu_wvalid  = 1'b0;
    mtime_model = '0;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      mem_model[i] = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // store then load, upper half
    repeat (N_PH1) begin
      idx = rand_range(512, 1023);
      store_random_word(idx);
      written.push_back(idx);
      lsu_load(word_addr(written[rand_range(0, written.size() - 1)]), "load after store");
    end

    // fetches from the upper half against load/store traffic in the lower half
    fork
      begin : fetch_stream
        repeat (N_FETCH) begin
          fetch(word_addr(rand_range(512, 1023)));
          ifu_idle(rand_range(0, 5));
        end
      end
      begin : lsu_stream
        repeat (N_LSU) begin
          if ($random(seed) & 1) begin
            store_random_word(rand_range(0, 511));
          end else begin
            lsu_load(word_addr(rand_range(0, 511)), "concurrent load");
          end
          lsu_idle(rand_range(0, 2));
        end
      end
    join

    repeat (N_TIMER) begin
      lsu_load(rand_range(0, 1) ? `CLINT_MTIME_HI_ADDR : `CLINT_MTIME_ADDR, "timer read");
      lsu_idle(rand_range(0, 3));
    end

    // bursts outrun the drain rate and fill the buffer
    repeat (N_BURSTS) begin
      repeat (BURST_LEN) begin
        lsu_store(`CONSOLE_ADDR, $random(seed), 4'h1);
      end
      lsu_idle(rand_range(0, 40));
    end

    // stores to the timer must not change what the timer returns
    lsu_store(`CLINT_MTIME_ADDR, $random(seed), 4'hf);
    lsu_load(`CLINT_MTIME_ADDR, "timer low after store");
    lsu_store(`CLINT_MTIME_HI_ADDR, $random(seed), 4'hf);
    lsu_load(`CLINT_MTIME_HI_ADDR, "timer high after store");

    while (con_q.size() != 0) begin
      lsu_idle(1);
    end
    lsu_idle(2 * `CONSOLE_DRAIN);
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- project.f
+incdir+hw
hw/bus_pkg.sv
hw/dev_pkg.sv
hw/mem_if.sv
hw/bus_arbiter.sv
hw/mem_sram.sv
hw/clint_timer.sv
hw/console_port.sv
hw/soc_bus_top.sv
dv/tb_soc_bus.sv
